// File: Makefile
TOP = mem_stage_tb

.PHONY: all lint clean

# Build, run, and pass only when the pass line shows up
all:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: all.f
logic/mem_pkg.sv
logic/mem_ctrl.sv
logic/store_align.sv
logic/data_mem.sv
logic/load_extract.sv
logic/mem_stage.sv
bench/mem_stage_checker.sv
bench/mem_stage_tb.sv

// File: bench/mem_stage_checker.sv
`timescale 1ns/1ns

module mem_stage_checker (
	input logic clk,
	input logic reset,
	input logic read_enable,
	input logic write_enable,
	input logic [31:0] read_result,
	input logic fault
);

	//////////////////////////////////////////////////////////////////////
	// Reset tracking
	//////////////////////////////////////////////////////////////////////

	// Set once the first reset edge has cleared fault
	logic reset_seen = 1'b0;

	// Count of failed assertions
	int failures = 0;

	always @(posedge clk) begin
		if (reset) begin
			reset_seen <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Fault pulse
	//////////////////////////////////////////////////////////////////////

	// Cleared by the time reset drops
	assert property (@(posedge clk) $fell(reset) |-> !fault)
		else begin
			failures++;
			$error("fault high in the first cycle after reset");
		end

	// Defined once reset has cleared it
	assert property (@(posedge clk) disable iff (reset || !reset_seen) !$isunknown(fault))
		else begin
			failures++;
			$error("fault is unknown after reset");
		end

	// Only an enabled access can fault
	assert property (@(posedge clk) disable iff (!reset_seen)
		fault |-> $past(read_enable || write_enable))
		else begin
			failures++;
			$error("fault without an enabled access in the previous cycle");
		end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk) !read_enable |-> read_result == 32'h0000_0000)
		else begin
			failures++;
			$error("read_result nonzero with read_enable low");
		end

endmodule

bind mem_stage mem_stage_checker u_mem_stage_checker (
	.clk(clk),
	.reset(reset),
	.read_enable(read_enable),
	.write_enable(write_enable),
	.read_result(read_result),
	.fault(fault)
);

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb;

	//////////////////////////////////////////////////////////////////////
	// DUT
	//////////////////////////////////////////////////////////////////////

	logic clk = 1'b0;
	logic reset;
	logic [31:0] read_addr;
	logic read_enable;
	mem_pkg::load_op_t load_op;
	logic [31:0] write_addr;
	logic [31:0] write_data;
	logic write_enable;
	mem_pkg::store_op_t store_op;
	logic [31:0] read_result;
	logic fault;

	mem_stage u_mem_stage (
		.clk(clk),
		.reset(reset),
		.read_addr(read_addr),
		.read_enable(read_enable),
		.load_op(load_op),
		.write_addr(write_addr),
		.write_data(write_data),
		.write_enable(write_enable),
		.store_op(store_op),
		.read_result(read_result),
		.fault(fault)
	);

	// Byte model of the 4 KiB memory, byte 0 lowest
	logic [7:0] model [0:4095];
	logic [31:0] rng_state;
	string test_name;
	int test_errors;
	int total_errors;
	int tests_passed;
	int tests_failed;

	// Inputs of the previous cycle
	logic have_prev;
	logic prev_reset;
	logic prev_read_enable;
	logic [31:0] prev_read_addr;
	mem_pkg::load_op_t prev_load_op;
	logic prev_write_enable;
	logic [31:0] prev_write_addr;
	mem_pkg::store_op_t prev_store_op;
	logic [31:0] exp_result;
	logic exp_fault;

	// 40 ns period
	initial begin
		forever begin
			#20 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic int load_size(input mem_pkg::load_op_t op);
		case (op)
			mem_pkg::load_word: return 4;
			mem_pkg::load_half, mem_pkg::load_half_u: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic int store_size(input mem_pkg::store_op_t op);
		case (op)
			mem_pkg::store_word: return 4;
			mem_pkg::store_half: return 2;
			default: return 1;
		endcase
	endfunction

	// In range and naturally aligned
	function automatic logic is_legal(input logic [31:0] addr, input int nbytes);
		logic aligned;
		case (nbytes)
			4: aligned = (addr[1:0] == 2'b00);
			2: aligned = !addr[0];
			default: aligned = 1'b1;
		endcase
		return (addr[31:12] == 20'h0) && aligned;
	endfunction

	function automatic logic [31:0] expect_load(input logic enable, input logic [31:0] addr,
			input mem_pkg::load_op_t op);
		logic [11:0] a;
		logic [15:0] half;
		logic [7:0] one;
		a = addr[11:0];
		if (!enable || !is_legal(addr, load_size(op))) begin
			return 32'h0000_0000;
		end
		one = model[a];
		half = {model[a + 12'd1], model[a]};
		case (op)
			mem_pkg::load_word: return {model[a + 12'd3], model[a + 12'd2], half};
			mem_pkg::load_half: return {{16{half[15]}}, half};
			mem_pkg::load_half_u: return {16'h0000, half};
			mem_pkg::load_byte: return {{24{one[7]}}, one};
			default: return {24'h000000, one};
		endcase
	endfunction

	// Fault follows any enabled illegal access unless reset was sampled
	function automatic logic expect_fault(input logic rst, input logic re,
			input logic [31:0] raddr, input mem_pkg::load_op_t lop, input logic we,
			input logic [31:0] waddr, input mem_pkg::store_op_t sop);
		if (rst) begin
			return 1'b0;
		end
		return (re && !is_legal(raddr, load_size(lop))) ||
			(we && !is_legal(waddr, store_size(sop)));
	endfunction

	task automatic store_model(input logic [31:0] addr, input logic [31:0] data, input int nbytes);
		for (int i = 0; i < nbytes; i++) begin
			model[addr[11:0] + 12'(i)] = data[8*i +: 8];
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic draw(output logic [31:0] value);
		rng_state = xorshift(rng_state);
		value = rng_state;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
		test_errors++;
		total_errors++;
	endtask

	// Inputs are stable mid-cycle, fault holds last cycle's verdict
	always @(negedge clk) begin
		exp_result = expect_load(read_enable, read_addr, load_op);
		if (read_result !== exp_result) begin
			report_mismatch("read_result", exp_result, read_result);
		end
		if (have_prev) begin
			exp_fault = expect_fault(prev_reset, prev_read_enable, prev_read_addr, prev_load_op,
				prev_write_enable, prev_write_addr, prev_store_op);
			if (fault !== exp_fault) begin
				report_mismatch("fault", {31'h0, exp_fault}, {31'h0, fault});
			end
		end
		prev_reset = reset;
		prev_read_enable = read_enable;
		prev_read_addr = read_addr;
		prev_load_op = load_op;
		prev_write_enable = write_enable;
		prev_write_addr = write_addr;
		prev_store_op = store_op;
		have_prev = 1'b1;
		// Write lands at the coming rising edge
		if (write_enable && is_legal(write_addr, store_size(store_op))) begin
			store_model(write_addr, write_data, store_size(store_op));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_timeout();
		$display("Timeout: no rising clock edge seen within 100 ns");
		$display("=== FAIL ===");
		$finish;
	endtask

	// Polls for low then high, bounded
	task automatic wait_rising_edge();
		int waited;
		waited = 0;
		while (clk !== 1'b0 && waited < 100) begin
			#1;
			waited++;
		end
		while (clk !== 1'b1 && waited < 100) begin
			#1;
			waited++;
		end
		if (waited >= 100) begin
			stop_on_timeout();
		end
	endtask

	task automatic apply_cycle(input logic re, input logic [31:0] raddr,
			input mem_pkg::load_op_t lop, input logic we, input logic [31:0] waddr,
			input logic [31:0] wdata, input mem_pkg::store_op_t sop);
		wait_rising_edge();
		// Clear of the edge
		#5;
		read_enable = re;
		read_addr = raddr;
		load_op = lop;
		write_enable = we;
		write_addr = waddr;
		write_data = wdata;
		store_op = sop;
	endtask

	task automatic idle_cycle();
		apply_cycle(1'b0, 32'h0, mem_pkg::load_word, 1'b0, 32'h0, 32'h0, mem_pkg::store_word);
	endtask

	task automatic read_cycle(input logic [31:0] addr, input mem_pkg::load_op_t op);
		apply_cycle(1'b1, addr, op, 1'b0, 32'h0, 32'h0, mem_pkg::store_word);
	endtask

	task automatic write_cycle(input logic [31:0] addr, input logic [31:0] data,
			input mem_pkg::store_op_t op);
		apply_cycle(1'b0, 32'h0, mem_pkg::load_word, 1'b1, addr, data, op);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	// Two idle cycles so the last fault pulse gets checked
	task automatic finish_test();
		idle_cycle();
		idle_cycle();
		if (test_errors == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("test %-12s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "failed",
			test_errors);
	endtask

	// Mostly in range, one in eight just past the end
	function automatic logic [31:0] random_addr(input logic [31:0] r);
		if (r[31:29] == 3'b000) begin
			return {19'h0, 1'b1, r[11:0]};
		end
		return {20'h0, r[11:0]};
	endfunction

	task automatic random_cycle();
		logic [31:0] r;
		logic [31:0] c;
		logic [31:0] raddr;
		logic [31:0] waddr;
		logic [31:0] wdata;
		draw(r);
		raddr = random_addr(r);
		draw(r);
		waddr = random_addr(r);
		draw(wdata);
		draw(c);
		// Bias toward aligned addresses
		if (c[12]) begin
			raddr[1:0] = 2'b00;
		end
		if (c[13]) begin
			waddr[1:0] = 2'b00;
		end
		apply_cycle(c[0] | c[1], raddr, mem_pkg::load_op_t'(3'(c % 32'd5)), c[2], waddr, wdata,
			mem_pkg::store_op_t'(2'((c >> 8) % 32'd3)));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		read_enable = 1'b0;
		read_addr = 32'h0;
		load_op = mem_pkg::load_word;
		write_enable = 1'b0;
		write_addr = 32'h0;
		write_data = 32'h0;
		store_op = mem_pkg::store_word;
		have_prev = 1'b0;
		rng_state = 32'd33;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		start_test("reset");
		repeat (8) begin
			wait_rising_edge();
		end
		#5;
		reset = 1'b0;
		finish_test();

		// Known words, then a read racing a write to the same word
		start_test("word_rw");
		write_cycle(32'h4, 32'h0123_4567, mem_pkg::store_word);
		apply_cycle(1'b1, 32'h4, mem_pkg::load_word, 1'b1, 32'h0, 32'h89ab_cdef,
			mem_pkg::store_word);
		read_cycle(32'h0, mem_pkg::load_word);
		apply_cycle(1'b1, 32'h0, mem_pkg::load_word, 1'b1, 32'h0, 32'h5a5a_0f0f,
			mem_pkg::store_word);
		read_cycle(32'h0, mem_pkg::load_word);
		finish_test();

		// Whole memory, each word read back a cycle later
		start_test("fill");
		for (int i = 0; i <= 1024; i++) begin
			apply_cycle(i != 0, 32'((i - 1) * 4), mem_pkg::load_word, i != 1024,
				32'(i * 4), {20'(i), 4'h5, ~8'(i)}, mem_pkg::store_word);
		end
		finish_test();

		start_test("merge");
		write_cycle(32'h101, 32'hdead_bea1, mem_pkg::store_byte);
		write_cycle(32'h102, 32'hffff_b2c3, mem_pkg::store_half);
		read_cycle(32'h100, mem_pkg::load_word);
		write_cycle(32'h100, 32'h0000_007f, mem_pkg::store_byte);
		write_cycle(32'h103, 32'h1234_5680, mem_pkg::store_byte);
		write_cycle(32'h104, 32'h7777_9e01, mem_pkg::store_half);
		read_cycle(32'h100, mem_pkg::load_word);
		read_cycle(32'h104, mem_pkg::load_word);
		finish_test();

		// Bit 7 and bit 15 set in several lanes
		start_test("extend");
		write_cycle(32'h200, 32'hf08c_807f, mem_pkg::store_word);
		write_cycle(32'h204, 32'h7f80_ff01, mem_pkg::store_word);
		for (int w = 0; w < 2; w++) begin
			for (int op = 0; op < 5; op++) begin
				for (int off = 0; off < 4; off++) begin
					if (is_legal(32'(512 + w * 4 + off), load_size(mem_pkg::load_op_t'(3'(op))))) begin
						read_cycle(32'(512 + w * 4 + off), mem_pkg::load_op_t'(3'(op)));
					end
				end
			end
		end
		finish_test();

		start_test("illegal");
		read_cycle(32'hfff, mem_pkg::load_word);
		idle_cycle();
		read_cycle(32'h1000, mem_pkg::load_byte);
		idle_cycle();
		read_cycle(32'h202, mem_pkg::load_word);
		write_cycle(32'h205, 32'h0000_beef, mem_pkg::store_half);
		read_cycle(32'h204, mem_pkg::load_word);
		write_cycle(32'h1000, 32'h1234_5678, mem_pkg::store_word);
		read_cycle(32'h0, mem_pkg::load_word);
		finish_test();

		start_test("random");
		repeat (300) begin
			random_cycle();
		end
		finish_test();

		// Reset in the cycle after a fault, with another bad read pending
		start_test("reset_fault");
		read_cycle(32'h1000, mem_pkg::load_byte);
		read_cycle(32'h1000, mem_pkg::load_byte);
		reset = 1'b1;
		idle_cycle();
		reset = 1'b0;
		idle_cycle();
		finish_test();

		$display("%0d tests passed, %0d failed, %0d errors, %0d assertion failures",
			tests_passed, tests_failed, total_errors, u_mem_stage.u_mem_stage_checker.failures);
		if (total_errors == 0 && tests_failed == 0 &&
				u_mem_stage.u_mem_stage_checker.failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/1ns

module data_mem (
	input logic clk,
	input logic [mem_pkg::dm_index_bits-1:0] read_index,
	input logic [mem_pkg::dm_index_bits-1:0] write_index,
	input logic write_strobe,
	input logic [3:0] byte_enable,
	input mem_pkg::mem_word_t lane_data,
	output mem_pkg::mem_word_t read_word
);

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Word-organised array, no reset as in a block RAM
	mem_pkg::mem_word_t mem [mem_pkg::dm_words];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	// Only enabled lanes change
	always_ff @(posedge clk) begin
		if (write_strobe) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_enable[i]) begin
					mem[write_index].bytes[i] <= lane_data.bytes[i];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Asynchronous read
	// A write to the same word lands at the edge, so the old value shows here
	assign read_word = mem[read_index];

endmodule

// File: logic/load_extract.sv
`timescale 1ns/1ns

module load_extract (
	input mem_pkg::mem_word_t read_word,
	input logic [1:0] byte_offset,
	input mem_pkg::load_op_t load_op,
	input logic load_ok,
	output logic [31:0] read_result
);

	//////////////////////////////////////////////////////////////////////
	// Lane select
	//////////////////////////////////////////////////////////////////////

	logic [15:0] half_sel;
	logic [7:0] byte_sel;
	logic [31:0] extended;

	// Upper half when offset bit 1 is set
	assign half_sel = read_word.halves[byte_offset[1]];
	// Addressed byte, lane 0 lowest
	assign byte_sel = read_word.bytes[byte_offset];

	//////////////////////////////////////////////////////////////////////
	// Extension
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (load_op)
			mem_pkg::load_word: extended = read_word.word;
			// Sign from bit 15
			mem_pkg::load_half: extended = {{16{half_sel[15]}}, half_sel};
			mem_pkg::load_half_u: extended = {16'h0000, half_sel};
			// Sign from bit 7
			mem_pkg::load_byte: extended = {{24{byte_sel[7]}}, byte_sel};
			mem_pkg::load_byte_u: extended = {24'h000000, byte_sel};
			default: extended = 32'h0000_0000;
		endcase
	end

	// Suppressed or idle reads give zero
	assign read_result = load_ok ? extended : 32'h0000_0000;

endmodule

// File: logic/mem_ctrl.sv
`timescale 1ns/1ns

module mem_ctrl (
	input logic clk,
	input logic reset,
	input logic [31:0] read_addr,
	input logic [31:0] write_addr,
	input logic read_enable,
	input logic write_enable,
	input mem_pkg::load_op_t load_op,
	input mem_pkg::store_op_t store_op,
	output logic load_ok,
	output logic store_ok,
	output logic fault
);

	//////////////////////////////////////////////////////////////////////
	// Range checks
	//////////////////////////////////////////////////////////////////////

	logic read_out_of_range;
	logic write_out_of_range;
	logic read_misaligned;
	logic write_misaligned;
	logic read_legal;
	logic write_legal;
	logic bad_access;

	// Anything above the decoded bits lies past the end of memory
	assign read_out_of_range = |read_addr[31:mem_pkg::dm_addr_bits];
	assign write_out_of_range = |write_addr[31:mem_pkg::dm_addr_bits];

	//////////////////////////////////////////////////////////////////////
	// Alignment checks
	//////////////////////////////////////////////////////////////////////

	// Load alignment by size
	always_comb begin
		case (load_op)
			mem_pkg::load_word: read_misaligned = |read_addr[1:0];
			mem_pkg::load_half,
			mem_pkg::load_half_u: read_misaligned = read_addr[0];
			mem_pkg::load_byte,
			mem_pkg::load_byte_u: read_misaligned = 1'b0;
			// Unused codes are never legal
			default: read_misaligned = 1'b1;
		endcase
	end

	// Store alignment by size
	always_comb begin
		case (store_op)
			mem_pkg::store_word: write_misaligned = |write_addr[1:0];
			mem_pkg::store_half: write_misaligned = write_addr[0];
			mem_pkg::store_byte: write_misaligned = 1'b0;
			// Unused code is never legal
			default: write_misaligned = 1'b1;
		endcase
	end

	assign read_legal = !read_out_of_range && !read_misaligned;
	assign write_legal = !write_out_of_range && !write_misaligned;

	// Gated enables for the datapath
	assign load_ok = read_enable && read_legal;
	assign store_ok = (write_enable == mem_pkg::dm_write_enabled) && write_legal;

	//////////////////////////////////////////////////////////////////////
	// Fault pulse
	//////////////////////////////////////////////////////////////////////

	// Any enabled access that got suppressed this cycle
	assign bad_access = (read_enable && !read_legal) || (write_enable && !write_legal);

	// Reported one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			fault <= 1'b0;
		end else begin
			fault <= bad_access;
		end
	end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Memory geometry
	//////////////////////////////////////////////////////////////////////

	// 4 KiB of data memory, byte addressed
	localparam int dm_addr_bits = 12;
	// Word index drops the two byte-offset bits
	localparam int dm_index_bits = dm_addr_bits - 2;
	// Depth in 32-bit words
	localparam int dm_words = 1024;

	// Write-enable levels
	localparam logic dm_write_enabled = 1'b1;
	localparam logic dm_write_disabled = 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Operation codes
	//////////////////////////////////////////////////////////////////////

	// Load size and extension
	typedef enum logic [2:0] {
		load_word,
		load_half,
		load_half_u,
		load_byte,
		load_byte_u
	} load_op_t;

	// Store size
	typedef enum logic [1:0] {
		store_word,
		store_half,
		store_byte
	} store_op_t;

	//////////////////////////////////////////////////////////////////////
	// Memory word views
	//////////////////////////////////////////////////////////////////////

	// One word seen whole, as byte lanes or as half lanes
	// Lane 0 is the least significant (little-endian)
	typedef union packed {
		logic [31:0] word;
		logic [3:0][7:0] bytes;
		logic [1:0][15:0] halves;
	} mem_word_t;

endpackage

// File: logic/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
	input logic clk,
	input logic reset,
	input logic [31:0] read_addr,
	input logic read_enable,
	input mem_pkg::load_op_t load_op,
	input logic [31:0] write_addr,
	input logic [31:0] write_data,
	input logic write_enable,
	input mem_pkg::store_op_t store_op,
	output logic [31:0] read_result,
	output logic fault
);

	//////////////////////////////////////////////////////////////////////
	// Internal wires
	//////////////////////////////////////////////////////////////////////

	logic load_ok;
	logic store_ok;
	logic [3:0] byte_enable;
	mem_pkg::mem_word_t lane_data;
	mem_pkg::mem_word_t read_word;

	// Legality and fault pulse
	mem_ctrl u_mem_ctrl (
		.clk(clk),
		.reset(reset),
		.read_addr(read_addr),
		.write_addr(write_addr),
		.read_enable(read_enable),
		.write_enable(write_enable),
		.load_op(load_op),
		.store_op(store_op),
		.load_ok(load_ok),
		.store_ok(store_ok),
		.fault(fault)
	);

	// Store lanes
	store_align u_store_align (
		.byte_offset(write_addr[1:0]),
		.write_data(write_data),
		.store_op(store_op),
		.byte_enable(byte_enable),
		.lane_data(lane_data)
	);

	// Word array, indexed by bits 11:2
	data_mem u_data_mem (
		.clk(clk),
		.read_index(read_addr[mem_pkg::dm_addr_bits-1:2]),
		.write_index(write_addr[mem_pkg::dm_addr_bits-1:2]),
		.write_strobe(store_ok),
		.byte_enable(byte_enable),
		.lane_data(lane_data),
		.read_word(read_word)
	);

	// Load select and extend
	load_extract u_load_extract (
		.read_word(read_word),
		.byte_offset(read_addr[1:0]),
		.load_op(load_op),
		.load_ok(load_ok),
		.read_result(read_result)
	);

endmodule

// File: logic/store_align.sv
`timescale 1ns/1ns

module store_align (
	input logic [1:0] byte_offset,
	input logic [31:0] write_data,
	input mem_pkg::store_op_t store_op,
	output logic [3:0] byte_enable,
	output mem_pkg::mem_word_t lane_data
);

	//////////////////////////////////////////////////////////////////////
	// Lane data
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Full word passes straight through
		lane_data.word = write_data;
		case (store_op)
			mem_pkg::store_half: begin
				// Low half copied into both half lanes
				for (int i = 0; i < 4; i++) begin
					lane_data.bytes[i] = (i % 2 == 0) ? write_data[7:0] : write_data[15:8];
				end
			end
			mem_pkg::store_byte: begin
				// Low byte copied into every lane
				for (int i = 0; i < 4; i++) begin
					lane_data.bytes[i] = write_data[7:0];
				end
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Byte enables
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (store_op)
			mem_pkg::store_word: byte_enable = 4'b1111;
			// Upper or lower half lane
			mem_pkg::store_half: byte_enable = byte_offset[1] ? 4'b1100 : 4'b0011;
			// Single lane picked by offset
			mem_pkg::store_byte: byte_enable = 4'b0001 << byte_offset;
			default: byte_enable = 4'b0000;
		endcase
	end

endmodule
